//--- rtl/color_pkg.sv
package color_pkg;

   typedef logic [31:0] addr_t;  // byte address
   typedef logic [31:0] word_t;
   typedef logic [31:0] vid_t;

   typedef enum logic [3:0] {
      TASK_CALC    = 4'd1,
      TASK_COLOR   = 4'd2,
      TASK_RECEIVE = 4'd3
   } task_type_e;

   // ts sits in the low word, args in the high word
   typedef struct packed {
      word_t       args;   // color for receive
      logic [7:0]  ttype;
      vid_t        hint;   // vertex id
      logic [31:0] ts;
   } task_t;

   typedef struct packed {
      addr_t      addr;
      logic [7:0] len;  // beats minus one
   } rd_req_t;

   typedef struct packed {
      addr_t addr;
      word_t data;
   } wr_req_t;

   typedef struct packed {
      addr_t edge_offset;
      addr_t neighbors;
      addr_t color;
      addr_t scratch;
   } graph_bases_t;

   // which captured field the current burst fills
   typedef enum logic [2:0] {
      SEL_NONE,
      SEL_OFFSETS,   // begin, end of own edge list
      SEL_NEIGHBOR,
      SEL_DEGREE,    // begin, end of neighbor's edge list
      SEL_BITMAP,
      SEL_SCRATCH    // bitmap, counter
   } fetch_sel_e;

   parameter int HEADER_BEATS         = 10;
   parameter int SCRATCH_STRIDE_SHIFT = 3;
   parameter int BITMAP_OFFSET        = 0;
   parameter int COUNTER_OFFSET       = 4;
   parameter int NUM_COLORS           = 32;

endpackage

//--- rtl/graph_header_regs.sv
module graph_header_regs #(
   parameter int ADDR_W = 32
) (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    rd_beat,
   input  color_pkg::word_t        rd_data,
   input  logic [3:0]              beat_idx,
   input  logic                    header_load,
   output color_pkg::graph_bases_t bases,
   output logic                    loaded
);
   import color_pkg::*;

   localparam addr_t ADDR_MASK = addr_t'({ADDR_W{1'b1}});

   addr_t byte_addr;
   logic  header_beat;

   // header holds word addresses
   assign byte_addr   = addr_t'({rd_data, 2'b00}) & ADDR_MASK;
   assign header_beat = header_load & rd_beat;

   always_ff @(posedge clk) begin
      if (header_beat) begin
         case (beat_idx)
            4'd3: bases.edge_offset <= byte_addr;
            4'd4: bases.neighbors   <= byte_addr;
            4'd5: bases.color       <= byte_addr;
            4'd7: bases.scratch     <= byte_addr;
            default: ;  // vertex/edge counts and spare words unused
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         loaded <= 1'b0;
      end else if (header_beat && beat_idx == 4'(HEADER_BEATS - 1)) begin
         loaded <= 1'b1;
      end
   end

   // header is fetched once per reset
   a_single_header: assert property (@(posedge clk) disable iff (!rstn)
      loaded |-> !(header_load && rd_beat));

endmodule

//--- rtl/vertex_fetch.sv
module vertex_fetch (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  rd_fire,
   input  logic                  rd_beat,
   input  color_pkg::word_t      rd_data,
   input  color_pkg::fetch_sel_e fetch_sel,
   input  logic                  clear_count,
   input  logic                  bump_count,
   output logic [3:0]            beat_idx,
   output color_pkg::word_t      eo_begin,
   output color_pkg::word_t      eo_end,
   output color_pkg::vid_t       edge_dest,
   output color_pkg::word_t      neighbor_degree,
   output color_pkg::word_t      bitmap,
   output color_pkg::word_t      join_counter
);
   import color_pkg::*;

   // last beat index of the burst each select expects
   function automatic logic [3:0] last_beat(fetch_sel_e sel);
      case (sel)
         SEL_OFFSETS, SEL_DEGREE, SEL_SCRATCH: return 4'd1;
         SEL_NEIGHBOR, SEL_BITMAP: return 4'd0;
         default: return 4'(HEADER_BEATS - 1);
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (!rstn) begin
         beat_idx <= '0;
      end else if (rd_fire) begin
         beat_idx <= '0;
      end else if (rd_beat) begin
         beat_idx <= beat_idx + 4'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_beat) begin
         case (fetch_sel)
            SEL_OFFSETS: begin
               if (beat_idx == 4'd0) begin
                  eo_begin <= rd_data;
               end else begin
                  eo_end <= rd_data;
               end
            end
            SEL_NEIGHBOR: edge_dest <= rd_data;
            SEL_DEGREE: begin
               if (beat_idx == 4'd0) begin
                  neighbor_degree <= rd_data;  // begin offset for now
               end else begin
                  neighbor_degree <= rd_data - neighbor_degree;
               end
            end
            SEL_BITMAP: bitmap <= rd_data;
            SEL_SCRATCH: begin
               if (beat_idx == 4'd0) begin
                  bitmap <= rd_data;
               end
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (clear_count) begin
         join_counter <= '0;
      end else if (bump_count) begin
         join_counter <= join_counter + 1'b1;
      end else if (rd_beat && fetch_sel == SEL_SCRATCH && beat_idx == 4'd1) begin
         join_counter <= rd_data;
      end
   end

   a_beat_in_burst: assert property (@(posedge clk) disable iff (!rstn)
      rd_beat |-> beat_idx <= last_beat(fetch_sel));

endmodule

//--- rtl/color_select.sv
module color_select (
   input  color_pkg::word_t bitmap,
   output logic [5:0]       color
);
   import color_pkg::*;

   word_t free;

   assign free = ~bitmap;

   // lowest free color wins
   always_comb begin
      color = 6'(NUM_COLORS);  // nothing free
      for (int i = NUM_COLORS - 1; i >= 0; i--) begin
         if (free[i]) begin
            color = 6'(i);
         end
      end
   end

endmodule

//--- rtl/color_task_fsm.sv
module color_task_fsm #(
   parameter int ADDR_W = 32
) (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    start,
   input  color_pkg::task_t        task_in,
   output logic                    done,
   output logic                    idle,
   output logic                    rd_valid,
   output color_pkg::rd_req_t      rd_req,
   input  logic                    rd_ready,
   input  logic                    rd_beat,
   input  logic                    rd_last,
   output logic                    wr_valid,
   output color_pkg::wr_req_t      wr_req,
   input  logic                    wr_ready,
   output logic                    task_valid,
   output color_pkg::task_t        task_out,
   input  logic                    task_ready,
   input  color_pkg::graph_bases_t bases,
   input  logic                    loaded,
   input  color_pkg::word_t        eo_begin,
   input  color_pkg::word_t        eo_end,
   input  color_pkg::vid_t         edge_dest,
   input  color_pkg::word_t        neighbor_degree,
   input  color_pkg::word_t        bitmap,
   input  color_pkg::word_t        join_counter,
   input  logic [5:0]              color,
   output color_pkg::fetch_sel_e   fetch_sel,
   output logic                    header_load,
   output logic                    clear_count,
   output logic                    bump_count
);
   import color_pkg::*;

   typedef enum logic [4:0] {
      S_IDLE, S_HDR_RD, S_HDR_WAIT, S_DISPATCH,
      S_OFS_RD, S_OFS_WAIT,       // own edge offsets
      S_NB_RD, S_NB_WAIT,         // next neighbor id
      S_DEG_RD, S_DEG_WAIT,       // neighbor's offsets
      S_NB_STEP,
      S_CNT_WR, S_ENQ_COLOR,
      S_BMP_RD, S_BMP_WAIT, S_COLOR_WR,
      S_SCR_RD, S_SCR_WAIT, S_BMP_WR, S_CNT_DEC_WR,
      S_FINISH
   } state_e;

   localparam addr_t ADDR_MASK = addr_t'({ADDR_W{1'b1}});

   state_e     state, state_next;
   task_t      cur_task;
   task_type_e cur_type;
   word_t      nb_idx;
   word_t      degree;
   word_t      edge_idx;
   addr_t      vtx_word;
   addr_t      scratch_entry;
   logic       walk_end;
   logic       nb_higher;
   logic       nb_lower;

   function automatic task_t make_task(task_type_e ttype, vid_t hint, word_t args);
      task_t t;
      t.ts    = '0;
      t.hint  = hint;
      t.ttype = {4'h0, ttype};
      t.args  = args;
      return t;
   endfunction

   assign cur_type      = task_type_e'(cur_task.ttype[3:0]);
   assign degree        = eo_end - eo_begin;
   assign edge_idx      = eo_begin + nb_idx;
   assign walk_end      = (edge_idx == eo_end);
   assign vtx_word      = cur_task.hint << 2;
   assign scratch_entry = bases.scratch + (cur_task.hint << SCRATCH_STRIDE_SHIFT);

   // priority order, ties broken by id
   assign nb_higher = (neighbor_degree > degree) ||
                      (neighbor_degree == degree && edge_dest < cur_task.hint);
   assign nb_lower  = (neighbor_degree < degree) ||
                      (neighbor_degree == degree && edge_dest > cur_task.hint);

   assign done        = (state == S_FINISH);
   assign idle        = (state == S_IDLE);
   assign header_load = (state == S_HDR_WAIT);
   assign clear_count = (state == S_DISPATCH) && (cur_type == TASK_CALC);

   always_comb begin
      case (state)
         S_OFS_WAIT: fetch_sel = SEL_OFFSETS;
         S_NB_WAIT:  fetch_sel = SEL_NEIGHBOR;
         S_DEG_WAIT: fetch_sel = SEL_DEGREE;
         S_BMP_WAIT: fetch_sel = SEL_BITMAP;
         S_SCR_WAIT: fetch_sel = SEL_SCRATCH;
         default:    fetch_sel = SEL_NONE;
      endcase
   end

   always_comb begin
      state_next = state;
      rd_valid   = 1'b0;
      rd_req     = '0;
      wr_valid   = 1'b0;
      wr_req     = '0;
      task_valid = 1'b0;
      task_out   = '0;
      bump_count = 1'b0;
      case (state)
         S_IDLE: begin
            if (start) begin
               state_next = loaded ? S_DISPATCH : S_HDR_RD;
            end
         end
         S_HDR_RD: begin
            rd_valid = 1'b1;
            rd_req   = '{addr: '0, len: 8'(HEADER_BEATS - 1)};
            if (rd_ready) state_next = S_HDR_WAIT;
         end
         S_HDR_WAIT: if (rd_beat && rd_last) state_next = S_DISPATCH;
         S_DISPATCH: begin
            case (cur_type)
               TASK_CALC:    state_next = S_OFS_RD;
               TASK_COLOR:   state_next = S_BMP_RD;
               TASK_RECEIVE: state_next = S_SCR_RD;
               default:      state_next = S_FINISH;  // unknown, drop
            endcase
         end
         S_OFS_RD: begin
            rd_valid = 1'b1;
            rd_req   = '{addr: bases.edge_offset + vtx_word, len: 8'd1};
            if (rd_ready) state_next = S_OFS_WAIT;
         end
         S_OFS_WAIT: if (rd_beat && rd_last) state_next = S_NB_RD;
         S_NB_RD: begin
            if (walk_end) begin
               state_next = (cur_type == TASK_CALC) ? S_CNT_WR : S_FINISH;
            end else begin
               rd_valid = 1'b1;
               rd_req   = '{addr: bases.neighbors + (edge_idx << 2), len: 8'd0};
               if (rd_ready) state_next = S_NB_WAIT;
            end
         end
         S_NB_WAIT: if (rd_beat && rd_last) state_next = S_DEG_RD;
         S_DEG_RD: begin
            rd_valid = 1'b1;
            rd_req   = '{addr: bases.edge_offset + (edge_dest << 2), len: 8'd1};
            if (rd_ready) state_next = S_DEG_WAIT;
         end
         S_DEG_WAIT: if (rd_beat && rd_last) state_next = S_NB_STEP;
         S_NB_STEP: begin
            if (cur_type == TASK_CALC) begin
               bump_count = nb_higher;
               state_next = S_NB_RD;
            end else if (nb_lower) begin
               task_valid = 1'b1;
               task_out   = make_task(TASK_RECEIVE, edge_dest, word_t'(color));
               if (task_ready) state_next = S_NB_RD;
            end else begin
               state_next = S_NB_RD;
            end
         end
         S_CNT_WR: begin
            wr_valid = 1'b1;
            wr_req   = '{addr: scratch_entry + COUNTER_OFFSET, data: join_counter};
            if (wr_ready) begin
               state_next = (join_counter == '0) ? S_ENQ_COLOR : S_FINISH;
            end
         end
         S_ENQ_COLOR: begin
            task_valid = 1'b1;
            task_out   = make_task(TASK_COLOR, cur_task.hint, '0);
            if (task_ready) state_next = S_FINISH;
         end
         S_BMP_RD: begin
            rd_valid = 1'b1;
            rd_req   = '{addr: scratch_entry + BITMAP_OFFSET, len: 8'd0};
            if (rd_ready) state_next = S_BMP_WAIT;
         end
         S_BMP_WAIT: if (rd_beat && rd_last) state_next = S_COLOR_WR;
         S_COLOR_WR: begin
            wr_valid = 1'b1;
            wr_req   = '{addr: bases.color + vtx_word, data: word_t'(color)};
            if (wr_ready) state_next = S_OFS_RD;  // then walk neighbors
         end
         S_SCR_RD: begin
            rd_valid = 1'b1;
            rd_req   = '{addr: scratch_entry, len: 8'd1};
            if (rd_ready) state_next = S_SCR_WAIT;
         end
         S_SCR_WAIT: if (rd_beat && rd_last) state_next = S_BMP_WR;
         S_BMP_WR: begin
            wr_valid = 1'b1;
            wr_req   = '{addr: scratch_entry + BITMAP_OFFSET,
                         data: bitmap | (word_t'(1) << cur_task.args)};
            if (wr_ready) state_next = S_CNT_DEC_WR;
         end
         S_CNT_DEC_WR: begin
            wr_valid = 1'b1;
            wr_req   = '{addr: scratch_entry + COUNTER_OFFSET, data: join_counter - 1'b1};
            if (wr_ready) begin
               state_next = (join_counter == word_t'(1)) ? S_ENQ_COLOR : S_FINISH;
            end
         end
         S_FINISH: state_next = S_IDLE;
         default: state_next = S_IDLE;
      endcase
      rd_req.addr = rd_req.addr & ADDR_MASK;
      wr_req.addr = wr_req.addr & ADDR_MASK;
   end

   always_ff @(posedge clk) begin
      if (idle && start) begin
         cur_task <= task_in;
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_DISPATCH) begin
         nb_idx <= '0;
      end else if (state == S_NB_STEP && state_next == S_NB_RD) begin
         nb_idx <= nb_idx + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= S_IDLE;
      end else begin
         state <= state_next;
      end
   end

   a_task_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_valid && !task_ready |=> task_valid && $stable(task_out));

endmodule

//--- rtl/color_top.sv
module color_top #(
   parameter int ADDR_W = 32
) (
   input  logic               clk,
   input  logic               rstn,
   input  logic               start,
   input  color_pkg::task_t   task_in,
   output logic               done,
   output logic               idle,
   output logic               rd_valid,
   output color_pkg::rd_req_t rd_req,
   input  logic               rd_ready,
   input  color_pkg::word_t   rd_data,
   input  logic               rd_beat,
   input  logic               rd_last,
   output logic               wr_valid,
   output color_pkg::wr_req_t wr_req,
   input  logic               wr_ready,
   output logic               task_valid,
   output color_pkg::task_t   task_out,
   input  logic               task_ready
);
   import color_pkg::*;

   graph_bases_t bases;
   fetch_sel_e   fetch_sel;
   logic         loaded;
   logic         header_load;
   logic         clear_count;
   logic         bump_count;
   logic         rd_fire;
   logic [3:0]   beat_idx;
   word_t        eo_begin;
   word_t        eo_end;
   vid_t         edge_dest;
   word_t        neighbor_degree;
   word_t        bitmap;
   word_t        join_counter;
   logic [5:0]   color;

   assign rd_fire = rd_valid & rd_ready;

   graph_header_regs #(.ADDR_W(ADDR_W)) graph_header_regs_inst (
      .clk         (clk),
      .rstn        (rstn),
      .rd_beat     (rd_beat),
      .rd_data     (rd_data),
      .beat_idx    (beat_idx),
      .header_load (header_load),
      .bases       (bases),
      .loaded      (loaded)
   );

   vertex_fetch vertex_fetch_inst (
      .clk             (clk),
      .rstn            (rstn),
      .rd_fire         (rd_fire),
      .rd_beat         (rd_beat),
      .rd_data         (rd_data),
      .fetch_sel       (fetch_sel),
      .clear_count     (clear_count),
      .bump_count      (bump_count),
      .beat_idx        (beat_idx),
      .eo_begin        (eo_begin),
      .eo_end          (eo_end),
      .edge_dest       (edge_dest),
      .neighbor_degree (neighbor_degree),
      .bitmap          (bitmap),
      .join_counter    (join_counter)
   );

   color_select color_select_inst (
      .bitmap (bitmap),
      .color  (color)
   );

   color_task_fsm #(.ADDR_W(ADDR_W)) color_task_fsm_inst (
      .clk             (clk),
      .rstn            (rstn),
      .start           (start),
      .task_in         (task_in),
      .done            (done),
      .idle            (idle),
      .rd_valid        (rd_valid),
      .rd_req          (rd_req),
      .rd_ready        (rd_ready),
      .rd_beat         (rd_beat),
      .rd_last         (rd_last),
      .wr_valid        (wr_valid),
      .wr_req          (wr_req),
      .wr_ready        (wr_ready),
      .task_valid      (task_valid),
      .task_out        (task_out),
      .task_ready      (task_ready),
      .bases           (bases),
      .loaded          (loaded),
      .eo_begin        (eo_begin),
      .eo_end          (eo_end),
      .edge_dest       (edge_dest),
      .neighbor_degree (neighbor_degree),
      .bitmap          (bitmap),
      .join_counter    (join_counter),
      .color           (color),
      .fetch_sel       (fetch_sel),
      .header_load     (header_load),
      .clear_count     (clear_count),
      .bump_count      (bump_count)
   );

endmodule

//--- dv/tb_graph_mem.sv
module tb_graph_mem #(
   parameter int          WORDS = 128,
   parameter logic [31:0] SEED  = 32'h6fe61da8
) (
   input  logic               clk,
   input  logic               rd_valid,
   input  color_pkg::rd_req_t rd_req,
   output logic               rd_ready,
   output color_pkg::word_t   rd_data,
   output logic               rd_beat,
   output logic               rd_last,
   input  logic               wr_valid,
   input  color_pkg::wr_req_t wr_req,
   output logic               wr_ready,
   output logic               task_ready
);
   import color_pkg::*;

   word_t       mem [WORDS];
   int unsigned beat_word;   // word index of the next beat
   int unsigned beats_left;

   task automatic poke(input int unsigned word_idx, input word_t data);
      mem[word_idx] = data;
   endtask

   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = 32'hc0de_0000 ^ i;  // unused words never read as zero
      end
   end

   initial begin
      rd_ready   = 1'b0;
      rd_data    = '0;
      rd_beat    = 1'b0;
      rd_last    = 1'b0;
      wr_ready   = 1'b1;
      task_ready = 1'b0;
      beat_word  = 0;
      beats_left = 0;
      void'($urandom(SEED));
      forever begin
         @(posedge clk);
         if (wr_valid && wr_ready) begin
            mem[wr_req.addr >> 2] = wr_req.data;
         end
         if (rd_valid && rd_ready) begin
            beat_word  = rd_req.addr >> 2;
            beats_left = rd_req.len + 1;
         end
         #1;
         rd_beat = (beats_left != 0);
         rd_last = (beats_left == 1);
         rd_data = rd_beat ? mem[beat_word] : '0;
         if (rd_beat) begin
            beat_word++;
            beats_left--;
         end
         rd_ready   = ($urandom_range(3) != 0);  // stall about one cycle in four
         wr_ready   = ($urandom_range(3) != 0);
         task_ready = ($urandom_range(2) != 0);  // and one in three here
      end
   end

endmodule

//--- dv/color_tb.sv
module color_tb;
   import color_pkg::*;

   localparam int CYCLE_LIMIT = 4000;  // tests need a few hundred cycles with stalls
   localparam int NV          = 6;
   localparam int EO_WORD     = 16;    // word bases of the graph regions
   localparam int NB_WORD     = 32;
   localparam int COLOR_WORD  = 64;
   localparam int SCR_WORD    = 80;

   logic    clk;
   logic    rstn;
   logic    start;
   task_t   task_in;
   logic    done;
   logic    idle;
   logic    rd_valid;
   rd_req_t rd_req;
   logic    rd_ready;
   word_t   rd_data;
   logic    rd_beat;
   logic    rd_last;
   logic    wr_valid;
   wr_req_t wr_req;
   logic    wr_ready;
   logic    task_valid;
   task_t   task_out;
   logic    task_ready;

   // vertex 0 and 3 share degree 3, vertex 4 and 5 degree 2
   int unsigned edge_ofs [NV + 1] = '{0, 3, 5, 9, 12, 14, 16};
   int unsigned adj [16] = '{1, 2, 3, 0, 2, 0, 1, 3, 4, 0, 2, 5, 2, 5, 3, 4};

   word_t   scr_bitmap [NV];
   word_t   scr_counter [NV];
   rd_req_t rd_log [$];
   wr_req_t wr_log [$];
   task_t   task_log [$];
   wr_req_t exp_wr [$];
   task_t   exp_tasks [$];
   int      errors = 0;
   int      checks = 0;
   int      cycles = 0;
   int      hdr_reads = 0;
   int      last_latency = 0;  // cycles of the latest task, acceptance to done

   color_top color_top_inst (
      .clk        (clk),
      .rstn       (rstn),
      .start      (start),
      .task_in    (task_in),
      .done       (done),
      .idle       (idle),
      .rd_valid   (rd_valid),
      .rd_req     (rd_req),
      .rd_ready   (rd_ready),
      .rd_data    (rd_data),
      .rd_beat    (rd_beat),
      .rd_last    (rd_last),
      .wr_valid   (wr_valid),
      .wr_req     (wr_req),
      .wr_ready   (wr_ready),
      .task_valid (task_valid),
      .task_out   (task_out),
      .task_ready (task_ready)
   );

   tb_graph_mem mem_inst (
      .clk        (clk),
      .rd_valid   (rd_valid),
      .rd_req     (rd_req),
      .rd_ready   (rd_ready),
      .rd_data    (rd_data),
      .rd_beat    (rd_beat),
      .rd_last    (rd_last),
      .wr_valid   (wr_valid),
      .wr_req     (wr_req),
      .wr_ready   (wr_ready),
      .task_ready (task_ready)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      if (rd_valid && rd_ready) begin
         rd_log.push_back(rd_req);
         if (rd_req.addr == '0 && rd_req.len == 8'd9) hdr_reads++;
      end
      if (wr_valid && wr_ready) wr_log.push_back(wr_req);
      if (task_valid && task_ready) task_log.push_back(task_out);
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("timeout: the tests did not finish within %0d cycles", cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   function automatic int unsigned degree_of(int unsigned v);
      return edge_ofs[v + 1] - edge_ofs[v];
   endfunction

   // u is colored before v
   function automatic logic ahead_of(int unsigned u, int unsigned v);
      return degree_of(u) > degree_of(v) || (degree_of(u) == degree_of(v) && u < v);
   endfunction

   function automatic task_t build_task(logic [7:0] tt, vid_t v, word_t args);
      task_t t;
      t       = '0;
      t.ttype = tt;
      t.hint  = v;
      t.args  = args;
      return t;
   endfunction

   function automatic wr_req_t write_of(addr_t addr, word_t data);
      wr_req_t w;
      w.addr = addr;
      w.data = data;
      return w;
   endfunction

   function automatic addr_t scratch_addr(int unsigned v);
      return SCR_WORD * 4 + 8 * v;
   endfunction

   task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic set_bitmap(input int unsigned v, input word_t b);
      mem_inst.poke(SCR_WORD + 2 * v, b);
      scr_bitmap[v] = b;
   endtask

   task automatic load_graph();
      mem_inst.poke(0, NV);
      mem_inst.poke(1, 16);
      mem_inst.poke(3, EO_WORD);
      mem_inst.poke(4, NB_WORD);
      mem_inst.poke(5, COLOR_WORD);
      mem_inst.poke(7, SCR_WORD);
      for (int v = 0; v <= NV; v++) mem_inst.poke(EO_WORD + v, edge_ofs[v]);
      for (int i = 0; i < 16; i++) mem_inst.poke(NB_WORD + i, adj[i]);
      for (int v = 0; v < NV; v++) begin
         set_bitmap(v, '0);
         mem_inst.poke(SCR_WORD + 2 * v + 1, '0);
         scr_counter[v] = '0;
      end
   endtask

   // runs one task to done, then compares writes and tasks in order
   task automatic run_task(input task_t t, input string name);
      rd_log.delete();
      wr_log.delete();
      task_log.delete();
      @(posedge clk);
      #1;
      task_in = t;
      start   = 1'b1;
      do @(posedge clk); while (!idle);
      #1;
      start        = 1'b0;
      last_latency = 1;
      do begin
         @(posedge clk);
         last_latency++;
      end while (!done);
      #1;
      check(wr_log.size(), exp_wr.size(), {name, " write count"});
      foreach (exp_wr[i]) begin
         if (i < wr_log.size()) check(wr_log[i], exp_wr[i], {name, " write"});
      end
      check(task_log.size(), exp_tasks.size(), {name, " task count"});
      foreach (exp_tasks[i]) begin
         if (i < task_log.size()) check(task_log[i], exp_tasks[i], {name, " task"});
      end
      exp_wr.delete();
      exp_tasks.delete();
   endtask

   task automatic calc_case(input int unsigned v);
      word_t cnt;
      cnt = '0;
      for (int unsigned i = edge_ofs[v]; i < edge_ofs[v + 1]; i++) begin
         if (ahead_of(adj[i], v)) cnt++;
      end
      exp_wr.push_back(write_of(scratch_addr(v) + 4, cnt));
      if (cnt == 0) exp_tasks.push_back(build_task(TASK_COLOR, v, '0));
      scr_counter[v] = cnt;
      run_task(build_task(TASK_CALC, v, '0), "calc");
   endtask

   task automatic color_case(input int unsigned v, input word_t b, input word_t exp_color);
      set_bitmap(v, b);
      exp_wr.push_back(write_of(COLOR_WORD * 4 + 4 * v, exp_color));
      for (int unsigned i = edge_ofs[v]; i < edge_ofs[v + 1]; i++) begin
         if (ahead_of(v, adj[i])) exp_tasks.push_back(build_task(TASK_RECEIVE, adj[i], exp_color));
      end
      run_task(build_task(TASK_COLOR, v, '0), "color");
   endtask

   task automatic receive_case(input int unsigned v, input int unsigned c);
      word_t b;
      word_t cnt;
      b   = scr_bitmap[v] | (32'h1 << c);
      cnt = scr_counter[v];
      exp_wr.push_back(write_of(scratch_addr(v), b));
      exp_wr.push_back(write_of(scratch_addr(v) + 4, cnt - 1));
      if (cnt == 1) exp_tasks.push_back(build_task(TASK_COLOR, v, '0));
      scr_bitmap[v]  = b;
      scr_counter[v] = cnt - 1;
      run_task(build_task(TASK_RECEIVE, v, c), "receive");
   endtask

   task automatic test_header();
      check(idle, 1'b1, "idle after reset");
      check({done, rd_valid, wr_valid, task_valid}, 4'b0, "outputs after reset");
      calc_case(2);  // first task, so the header comes first
      check(rd_log.size() > 0, 1'b1, "first task read count");
      if (rd_log.size() > 0) check(rd_log[0], {32'h0, 8'd9}, "header read");
   endtask

   task automatic test_calc();
      for (int unsigned v = 0; v < NV; v++) calc_case(v);
   endtask

   task automatic test_color();
      color_case(0, 32'h0, 0);
      color_case(3, 32'h7, 3);  // tie with vertex 0
      color_case(2, 32'hffff_ffff, 32);
   endtask

   task automatic test_receive();
      receive_case(4, 5);
      receive_case(1, 2);
      receive_case(1, 0);  // counter reaches zero here
   endtask

   task automatic test_stalled_tasks();
      color_case(2, 32'h0000_00ff, 8);
      color_case(0, 32'h1, 1);
   endtask

   task automatic test_unknown();
      run_task(build_task(8'h7, 1, '0), "unknown");
      check(rd_log.size(), 0, "unknown read count");
      check(last_latency, 3, "unknown latency");
   endtask

   initial begin
      clk     = 1'b0;
      rstn    = 1'b0;
      start   = 1'b0;
      task_in = '0;
      repeat (10) @(posedge clk);
      #1;
      rstn = 1'b1;
      load_graph();
      test_header();
      test_calc();
      test_color();
      test_receive();
      test_stalled_tasks();
      test_unknown();
      check(hdr_reads, 1, "header read count");
      $display("errors: %0d in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- build.f
rtl/color_pkg.sv
rtl/graph_header_regs.sv
rtl/vertex_fetch.sv
rtl/color_select.sv
rtl/color_task_fsm.sv
rtl/color_top.sv
dv/tb_graph_mem.sv
dv/color_tb.sv
